// ==== logic/rs5_pkg.sv ====
package rs5_pkg;

    //////////////////////////////
    // Geometry
    //////////////////////////////

    localparam int XLEN     = 32;
    // x0 included, though never stored
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    // Jump tag, bumped on each redirect
    typedef logic [2:0]      tag_t;

    localparam xlen_t      RESET_PC  = '0;
    localparam xlen_t      PC_STEP   = 32'd4;
    // Word stores only
    localparam logic [3:0] STRB_WORD = 4'b1111;

    //////////////////////////////
    // Major opcodes
    //////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Operation carried into execute
    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_LUI, OP_LW, OP_SW, OP_BEQ, OP_BNE, OP_JAL
    } inst_op_e;

    //////////////////////////////
    // Stage bundles
    //////////////////////////////

    // Decode to execute
    typedef struct packed {
        inst_op_e  op;
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     first_operand;
        // rs2 value or immediate
        xlen_t     second_operand;
        // Store data or branch/jump offset
        xlen_t     third_operand;
        tag_t      tag;
    } exec_bundle_t;

    // Execute to register bank
    typedef struct packed {
        logic      write_enable;
        logic      is_load;
        reg_addr_t rd;
        xlen_t     result;
    } retire_bundle_t;

    // Data memory request
    typedef struct packed {
        logic       enable;
        logic [3:0] write_strobe;
        xlen_t      address;
        xlen_t      write_data;
    } mem_req_t;

endpackage

// ==== logic/fetch.sv ====
`timescale 1ns/10ps

module fetch (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           enable_i,
    input  logic           jump_i,
    input  rs5_pkg::xlen_t jump_target_i,
    output rs5_pkg::xlen_t instruction_address_o,
    output rs5_pkg::xlen_t pc_o,
    output rs5_pkg::tag_t  tag_o
);

    // Address side, what memory sees now
    rs5_pkg::xlen_t addr_q;
    rs5_pkg::tag_t  addr_tag_q;
    // Decode side, one cycle behind
    rs5_pkg::xlen_t pc_q;
    rs5_pkg::tag_t  tag_q;

    // Redirect wins over a freeze
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q     <= rs5_pkg::RESET_PC;
            addr_tag_q <= '0;
        end else if (jump_i) begin
            addr_q     <= jump_target_i;
            // New path, new tag
            addr_tag_q <= rs5_pkg::tag_t'(addr_tag_q + 1'b1);
        end else if (enable_i) begin
            addr_q <= addr_q + rs5_pkg::PC_STEP;
        end
    end

    // Follows the address by one cycle, with the memory latency
    // Reset tag differs from execute so the word seen right after reset dies
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q  <= rs5_pkg::RESET_PC;
            tag_q <= '1;
        end else if (jump_i || enable_i) begin
            pc_q  <= addr_q;
            tag_q <= addr_tag_q;
        end
    end

    assign instruction_address_o = addr_q;
    assign pc_o                  = pc_q;
    assign tag_o                 = tag_q;

    // Branch and jump targets from execute keep fetch word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        instruction_address_o[1:0] == 2'b00);

endmodule

// ==== logic/decode.sv ====
`timescale 1ns/10ps

module decode (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  rs5_pkg::xlen_t        instruction_i,
    input  rs5_pkg::xlen_t        pc_i,
    input  rs5_pkg::tag_t         tag_i,
    input  rs5_pkg::xlen_t        rs1_data_i,
    input  rs5_pkg::xlen_t        rs2_data_i,
    output rs5_pkg::reg_addr_t    rs1_o,
    output rs5_pkg::reg_addr_t    rs2_o,
    output rs5_pkg::exec_bundle_t exec_o,
    output logic                  hazard_o
);

    rs5_pkg::xlen_t        instr;
    rs5_pkg::xlen_t        inst_hold_q;
    logic                  hold_valid_q;
    logic                  advance;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rs5_pkg::inst_op_e     op;
    rs5_pkg::xlen_t        imm_i, imm_s, imm_b, imm_u, imm_j;
    rs5_pkg::exec_bundle_t next_bundle;
    rs5_pkg::exec_bundle_t exec_q;

    //////////////////////////////
    // Instruction hold
    //////////////////////////////

    // Memory moves on while we are frozen, so keep the first word seen
    assign advance = !(stall_i || hazard_o);
    assign instr   = hold_valid_q ? inst_hold_q : instruction_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_valid_q <= 1'b0;
        end else begin
            hold_valid_q <= !advance;
        end
    end

    always_ff @(posedge clk) begin
        if (!advance && !hold_valid_q) begin
            inst_hold_q <= instruction_i;
        end
    end

    //////////////////////////////
    // Fields and immediates
    //////////////////////////////

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Anything outside the subset falls to NOP
    always_comb begin
        op = rs5_pkg::OP_NOP;
        case (opcode)
            rs5_pkg::OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = rs5_pkg::OP_ADD;
                        3'b010:  op = rs5_pkg::OP_SLT;
                        3'b100:  op = rs5_pkg::OP_XOR;
                        3'b110:  op = rs5_pkg::OP_OR;
                        3'b111:  op = rs5_pkg::OP_AND;
                        default: op = rs5_pkg::OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = rs5_pkg::OP_SUB;
                end
            end
            // ADDI shares the adder
            rs5_pkg::OPC_OP_IMM: if (funct3 == 3'b000) op = rs5_pkg::OP_ADD;
            rs5_pkg::OPC_LUI:    op = rs5_pkg::OP_LUI;
            rs5_pkg::OPC_LOAD:   if (funct3 == 3'b010) op = rs5_pkg::OP_LW;
            rs5_pkg::OPC_STORE:  if (funct3 == 3'b010) op = rs5_pkg::OP_SW;
            rs5_pkg::OPC_BRANCH: begin
                if (funct3 == 3'b000) op = rs5_pkg::OP_BEQ;
                if (funct3 == 3'b001) op = rs5_pkg::OP_BNE;
            end
            rs5_pkg::OPC_JAL:    op = rs5_pkg::OP_JAL;
            default:             op = rs5_pkg::OP_NOP;
        endcase
    end

    //////////////////////////////
    // Bundle
    //////////////////////////////

    always_comb begin
        next_bundle.op             = hazard_o ? rs5_pkg::OP_NOP : op;
        next_bundle.pc             = pc_i;
        next_bundle.rd             = instr[11:7];
        next_bundle.first_operand  = rs1_data_i;
        next_bundle.tag            = tag_i;
        // Second operand
        case (opcode)
            rs5_pkg::OPC_OP_IMM, rs5_pkg::OPC_LOAD: next_bundle.second_operand = imm_i;
            rs5_pkg::OPC_STORE:                     next_bundle.second_operand = imm_s;
            rs5_pkg::OPC_LUI:                       next_bundle.second_operand = imm_u;
            default:                                next_bundle.second_operand = rs2_data_i;
        endcase
        // Third operand, offsets for control flow
        case (opcode)
            rs5_pkg::OPC_BRANCH: next_bundle.third_operand = imm_b;
            rs5_pkg::OPC_JAL:    next_bundle.third_operand = imm_j;
            default:             next_bundle.third_operand = rs2_data_i;
        endcase
    end

    // Load in execute feeding this instruction, bubble once
    assign hazard_o = exec_q.op == rs5_pkg::OP_LW && exec_q.rd != '0
                      && (exec_q.rd == rs1_o || exec_q.rd == rs2_o);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exec_q    <= '0;
            exec_q.op <= rs5_pkg::OP_NOP;
        end else if (!stall_i) begin
            exec_q <= next_bundle;
        end
    end

    assign exec_o = exec_q;

    // Bubble clears the load, so no back to back hazard
    a_hazard_once: assert property (@(posedge clk) disable iff (!arst_n_i)
        hazard_o && !stall_i |=> !hazard_o);

endmodule

// ==== logic/regbank.sv ====
`timescale 1ns/10ps

module regbank (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  rs5_pkg::reg_addr_t      rs1_i,
    input  rs5_pkg::reg_addr_t      rs2_i,
    input  rs5_pkg::retire_bundle_t retire_i,
    input  rs5_pkg::xlen_t          mem_data_i,
    output rs5_pkg::xlen_t          rs1_data_o,
    output rs5_pkg::xlen_t          rs2_data_o
);

    // x1..x31, x0 is hardwired
    rs5_pkg::xlen_t     regs_q [1:rs5_pkg::NUM_REGS-1];
    rs5_pkg::xlen_t     wb_data;
    logic               wb_en;
    rs5_pkg::reg_addr_t rd_addr [2];
    rs5_pkg::xlen_t     rd_data [2];

    //////////////////////////////
    // Writeback
    //////////////////////////////

    // Load data lands the cycle after the request
    assign wb_data = retire_i.is_load ? mem_data_i : retire_i.result;
    // Drop writes to x0
    assign wb_en   = retire_i.write_enable && retire_i.rd != '0;

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs_q[retire_i.rd] <= wb_data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    assign rd_addr[0] = rs1_i;
    assign rd_addr[1] = rs2_i;

    // Write-through, same cycle value wins over the array
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;
            end else if (wb_en && rd_addr[p] == retire_i.rd) begin
                rd_data[p] = wb_data;
            end else begin
                rd_data[p] = regs_q[rd_addr[p]];
            end
        end
    end

    assign rs1_data_o = rd_data[0];
    assign rs2_data_o = rd_data[1];

    // x0 stays zero even while retire targets it
    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rs1_i == '0 |-> rs1_data_o == '0) and (rs2_i == '0 |-> rs2_data_o == '0));

endmodule

// ==== logic/execute.sv ====
`timescale 1ns/10ps

module execute (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    stall_i,
    input  rs5_pkg::exec_bundle_t   exec_i,
    output logic                    jump_o,
    output rs5_pkg::xlen_t          jump_target_o,
    output rs5_pkg::mem_req_t       mem_req_o,
    output rs5_pkg::retire_bundle_t retire_o
);

    rs5_pkg::tag_t           tag_q;
    logic                    killed;
    logic                    taken;
    logic                    is_mem;
    logic                    writes_rd;
    rs5_pkg::xlen_t          sum;
    rs5_pkg::xlen_t          result;
    rs5_pkg::retire_bundle_t retire_d;
    rs5_pkg::retire_bundle_t retire_q;

    //////////////////////////////
    // Tag check
    //////////////////////////////

    // Stale tag means fetched before our last redirect
    assign killed = exec_i.tag != tag_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tag_q <= '0;
        end else if (jump_o) begin
            tag_q <= rs5_pkg::tag_t'(tag_q + 1'b1);
        end
    end

    //////////////////////////////
    // ALU
    //////////////////////////////

    // Also the load/store address
    assign sum = exec_i.first_operand + exec_i.second_operand;

    always_comb begin
        case (exec_i.op)
            rs5_pkg::OP_ADD: result = sum;
            rs5_pkg::OP_SUB: result = exec_i.first_operand - exec_i.second_operand;
            rs5_pkg::OP_AND: result = exec_i.first_operand & exec_i.second_operand;
            rs5_pkg::OP_OR:  result = exec_i.first_operand | exec_i.second_operand;
            rs5_pkg::OP_XOR: result = exec_i.first_operand ^ exec_i.second_operand;
            rs5_pkg::OP_SLT: begin
                result = rs5_pkg::xlen_t'($signed(exec_i.first_operand)
                                          < $signed(exec_i.second_operand));
            end
            rs5_pkg::OP_LUI: result = exec_i.second_operand;
            // Link address
            rs5_pkg::OP_JAL: result = exec_i.pc + rs5_pkg::PC_STEP;
            default:         result = sum;
        endcase
    end

    //////////////////////////////
    // Branch resolution
    //////////////////////////////

    always_comb begin
        case (exec_i.op)
            rs5_pkg::OP_BEQ: taken = exec_i.first_operand == exec_i.second_operand;
            rs5_pkg::OP_BNE: taken = exec_i.first_operand != exec_i.second_operand;
            rs5_pkg::OP_JAL: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // Held back during stall, fetch and tag move once per instruction
    assign jump_o        = taken && !killed && !stall_i;
    assign jump_target_o = exec_i.pc + exec_i.third_operand;

    //////////////////////////////
    // Memory request
    //////////////////////////////

    assign is_mem = exec_i.op == rs5_pkg::OP_LW || exec_i.op == rs5_pkg::OP_SW;

    // Stays up while stalled, memory keeps it pending
    assign mem_req_o.enable       = is_mem && !killed;
    assign mem_req_o.write_strobe = (exec_i.op == rs5_pkg::OP_SW && !killed)
                                    ? rs5_pkg::STRB_WORD : 4'b0000;
    assign mem_req_o.address      = sum;
    assign mem_req_o.write_data   = exec_i.third_operand;

    //////////////////////////////
    // Retire
    //////////////////////////////

    assign writes_rd = exec_i.op inside {rs5_pkg::OP_ADD, rs5_pkg::OP_SUB, rs5_pkg::OP_AND,
                                         rs5_pkg::OP_OR, rs5_pkg::OP_XOR, rs5_pkg::OP_SLT,
                                         rs5_pkg::OP_LUI, rs5_pkg::OP_LW, rs5_pkg::OP_JAL};

    always_comb begin
        retire_d.write_enable = writes_rd && !killed;
        retire_d.is_load      = exec_i.op == rs5_pkg::OP_LW;
        retire_d.rd           = exec_i.rd;
        retire_d.result       = result;
    end

    // Write fires once; load data may change under a long stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_q <= '0;
        end else if (stall_i) begin
            retire_q.write_enable <= 1'b0;
        end else begin
            retire_q <= retire_d;
        end
    end

    assign retire_o = retire_q;

    // Word behind a redirect was fetched on the old path
    a_wrong_path_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        jump_o |=> !jump_o && !mem_req_o.enable);

endmodule

// ==== logic/rs5_core.sv ====
`timescale 1ns/10ps

module rs5_core (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  rs5_pkg::xlen_t    instruction_i,
    input  rs5_pkg::xlen_t    mem_data_i,
    output rs5_pkg::xlen_t    instruction_address_o,
    output rs5_pkg::mem_req_t mem_req_o
);

    //////////////////////////////
    // Stage links
    //////////////////////////////

    logic                    enable_fetch;
    logic                    hazard;
    logic                    jump;
    rs5_pkg::xlen_t          jump_target;
    rs5_pkg::xlen_t          pc_decode;
    rs5_pkg::tag_t           tag_decode;
    rs5_pkg::reg_addr_t      rs1, rs2;
    rs5_pkg::xlen_t          rs1_data, rs2_data;
    rs5_pkg::exec_bundle_t   exec_bundle;
    rs5_pkg::retire_bundle_t retire_bundle;

    // Fetch halts on a memory stall or a load-use bubble
    assign enable_fetch = ~(stall_i | hazard);

    fetch fetch_i (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .enable_i              (enable_fetch),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode),
        .tag_o                 (tag_decode)
    );

    decode decode_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .tag_i         (tag_decode),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .exec_o        (exec_bundle),
        .hazard_o      (hazard)
    );

    // Writeback happens inside the bank
    regbank regbank_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .retire_i   (retire_bundle),
        .mem_data_i (mem_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute execute_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .exec_i        (exec_bundle),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .mem_req_o     (mem_req_o),
        .retire_o      (retire_bundle)
    );

endmodule

// ==== tb/tb_memory.sv ====
`timescale 1ns/10ps

module tb_memory (
    input  logic              clk,
    input  logic              stall_i,
    input  rs5_pkg::xlen_t    instruction_address_i,
    input  rs5_pkg::mem_req_t mem_req_i,
    output rs5_pkg::xlen_t    instruction_o,
    output rs5_pkg::xlen_t    mem_data_o
);

    localparam logic [31:0] NOP = 32'h0000_0013;

    logic [31:0] rom [64];
    logic [31:0] ram [512];

    //////////////////////////////
    // Instruction encoders
    //////////////////////////////

    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // Serves ADDI and LW through f3 and the opcode
    function automatic logic [31:0] imm_op(input logic [31:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sw_at(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_to(input logic [31:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] upper(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] link_jump(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    //////////////////////////////
    // Test program
    //////////////////////////////

    // Producers sit at least two slots ahead of their consumers
    initial begin
        instruction_o = NOP;
        for (int i = 0; i < 64; i++) begin
            rom[i] = NOP;
        end
        // Operands
        rom[0]  = imm_op(25, 0, 3'b000, 1, 7'b0010011);
        rom[1]  = imm_op(-7, 0, 3'b000, 2, 7'b0010011);
        rom[2]  = upper(20'h12345, 3);
        // ALU results
        rom[3]  = reg_op(7'h00, 2, 1, 3'b000, 4);
        rom[4]  = reg_op(7'h20, 2, 1, 3'b000, 5);
        rom[5]  = reg_op(7'h00, 1, 3, 3'b110, 6);
        rom[6]  = reg_op(7'h00, 2, 3, 3'b100, 7);
        rom[7]  = reg_op(7'h00, 5, 2, 3'b111, 8);
        rom[8]  = reg_op(7'h00, 1, 2, 3'b010, 9);
        rom[9]  = reg_op(7'h00, 2, 1, 3'b010, 10);
        rom[10] = sw_at(32'h400, 4, 0);
        rom[11] = sw_at(32'h404, 5, 0);
        rom[12] = sw_at(32'h408, 6, 0);
        rom[13] = sw_at(32'h40C, 7, 0);
        rom[14] = sw_at(32'h410, 8, 0);
        rom[15] = sw_at(32'h414, 9, 0);
        rom[16] = sw_at(32'h418, 10, 0);
        rom[17] = sw_at(32'h41C, 3, 0);
        rom[18] = sw_at(32'h420, 2, 0);
        // Two interleaved chains where each step reads the value retiring that cycle
        rom[19] = imm_op(100, 0, 3'b000, 11, 7'b0010011);
        rom[20] = imm_op(3, 0, 3'b000, 12, 7'b0010011);
        rom[21] = reg_op(7'h00, 11, 11, 3'b000, 11);
        rom[22] = reg_op(7'h20, 1, 12, 3'b000, 12);
        rom[23] = reg_op(7'h00, 2, 11, 3'b100, 11);
        rom[24] = reg_op(7'h00, 4, 12, 3'b110, 12);
        rom[25] = reg_op(7'h00, 1, 11, 3'b000, 11);
        rom[26] = reg_op(7'h00, 6, 12, 3'b111, 12);
        rom[27] = sw_at(32'h424, 11, 0);
        rom[28] = sw_at(32'h428, 12, 0);
        // Load-use pairs
        rom[29] = imm_op(32'h200, 0, 3'b010, 13, 7'b0000011);
        rom[30] = reg_op(7'h00, 1, 13, 3'b000, 14);
        rom[31] = imm_op(32'h404, 0, 3'b010, 15, 7'b0000011);
        rom[32] = reg_op(7'h20, 13, 15, 3'b000, 16);
        rom[33] = sw_at(32'h42C, 14, 0);
        rom[34] = sw_at(32'h430, 16, 0);
        rom[35] = imm_op(32'h208, 0, 3'b010, 17, 7'b0000011);
        rom[36] = sw_at(32'h434, 17, 0);
        // Every poison store below sits on a skipped path
        rom[37] = branch_to(12, 1, 1, 3'b000);
        rom[38] = sw_at(32'h7F0, 1, 0);
        rom[39] = sw_at(32'h7F0, 1, 0);
        rom[40] = branch_to(8, 2, 1, 3'b001);
        rom[41] = sw_at(32'h7F0, 1, 0);
        // Not taken
        rom[42] = branch_to(8, 2, 1, 3'b000);
        rom[43] = sw_at(32'h438, 5, 0);
        rom[44] = link_jump(12, 18);
        rom[45] = sw_at(32'h7F0, 1, 0);
        rom[46] = sw_at(32'h7F0, 1, 0);
        // x0 stays zero
        rom[47] = imm_op(55, 0, 3'b000, 0, 7'b0010011);
        rom[48] = sw_at(32'h43C, 18, 0);
        rom[49] = sw_at(32'h440, 0, 0);
        rom[50] = sw_at(32'h444, 1, 0);
        // Park here
        rom[51] = link_jump(0, 0);
    end

    //////////////////////////////
    // Memories
    //////////////////////////////

    // Each word starts as a marker plus its own byte address
    initial begin
        mem_data_o = '0;
        for (int i = 0; i < 512; i++) begin
            ram[i] = 32'h5a00_0000 + (i << 2);
        end
    end

    always @(posedge clk) begin
        instruction_o <= rom[instruction_address_i[7:2]];
    end

    // Write lands when the stall lifts
    // Read data comes one cycle later
    always @(posedge clk) begin
        if (mem_req_i.enable) begin
            if (|mem_req_i.write_strobe) begin
                if (!stall_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req_i.write_strobe[b]) begin
                            ram[mem_req_i.address[10:2]][8*b +: 8] <=
                                mem_req_i.write_data[8*b +: 8];
                        end
                    end
                end
            end else begin
                mem_data_o <= ram[mem_req_i.address[10:2]];
            end
        end
    end

endmodule

// ==== tb/tb_rs5.sv ====
`timescale 1ns/10ps

module tb_rs5;

    localparam rs5_pkg::xlen_t FINAL_ADDR = 32'h444;
    localparam int             MAX_CYCLES = 3000;

    logic              clk;
    logic              arst_n;
    logic              stall;
    rs5_pkg::xlen_t    instruction;
    rs5_pkg::xlen_t    mem_data;
    rs5_pkg::xlen_t    instruction_address;
    rs5_pkg::mem_req_t mem_req;

    integer seed;
    int     errors;
    int     checked;
    int     missing;

    // Expected stores by word address
    logic           exp_valid [512];
    rs5_pkg::xlen_t exp_data  [512];
    string          exp_name  [512];
    int             seen      [512];

    // Write request as seen at the last rising edge
    logic           wr_q;
    rs5_pkg::xlen_t wr_addr_q;
    rs5_pkg::xlen_t wr_data_q;
    logic [3:0]     wr_strb_q;

    rs5_core dut_i (
        .clk                   (clk),
        .arst_n_i              (arst_n),
        .stall_i               (stall),
        .instruction_i         (instruction),
        .mem_data_i            (mem_data),
        .instruction_address_o (instruction_address),
        .mem_req_o             (mem_req)
    );

    tb_memory memory_i (
        .clk                   (clk),
        .stall_i               (stall),
        .instruction_address_i (instruction_address),
        .mem_req_i             (mem_req),
        .instruction_o         (instruction),
        .mem_data_o            (mem_data)
    );

    //////////////////////////////
    // Expected values
    //////////////////////////////

    function automatic logic known_address(input rs5_pkg::xlen_t addr);
        return addr[31:11] == '0 && addr[1:0] == 2'b00 && exp_valid[addr[10:2]];
    endfunction

    task automatic expect_store(input rs5_pkg::xlen_t addr, input rs5_pkg::xlen_t data,
                                input string name);
        exp_valid[addr[10:2]] = 1'b1;
        exp_data[addr[10:2]]  = data;
        exp_name[addr[10:2]]  = name;
    endtask

    initial begin
        for (int i = 0; i < 512; i++) begin
            exp_valid[i] = 1'b0;
            exp_data[i]  = '0;
            seen[i]      = 0;
        end
        expect_store(32'h400, 32'h0000_0012, "add");
        expect_store(32'h404, 32'h0000_0020, "sub");
        expect_store(32'h408, 32'h1234_5019, "or");
        expect_store(32'h40C, 32'hEDCB_AFF9, "xor");
        expect_store(32'h410, 32'h0000_0020, "and");
        expect_store(32'h414, 32'h0000_0001, "slt_true");
        expect_store(32'h418, 32'h0000_0000, "slt_false");
        expect_store(32'h41C, 32'h1234_5000, "lui");
        expect_store(32'h420, 32'hFFFF_FFF9, "addi_negative");
        expect_store(32'h424, 32'hFFFF_FF4A, "chain_a");
        expect_store(32'h428, 32'h1234_5018, "chain_b");
        // RAM words hold a marker plus their address
        expect_store(32'h42C, 32'h5A00_0219, "load_use_add");
        expect_store(32'h430, 32'hA5FF_FE20, "load_use_sub");
        expect_store(32'h434, 32'h5A00_0208, "load_then_store");
        expect_store(32'h438, 32'h0000_0020, "beq_not_taken");
        // Link of the JAL at 0xB0
        expect_store(32'h43C, 32'h0000_00B4, "jal_link");
        expect_store(32'h440, 32'h0000_0000, "x0_write");
        expect_store(FINAL_ADDR, 32'h0000_0019, "final");
    end

    //////////////////////////////
    // Clock, reset, stall
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (arst_n) begin
            // Roughly one cycle in four
            stall <= ($random(seed) & 3) == 0;
        end
    end

    //////////////////////////////
    // Store checks
    //////////////////////////////

    always @(posedge clk) begin
        wr_q      <= arst_n && mem_req.enable && |mem_req.write_strobe && !stall;
        wr_addr_q <= mem_req.address;
        wr_data_q <= mem_req.write_data;
        wr_strb_q <= mem_req.write_strobe;
    end

    always @(negedge clk) begin
        if (wr_q && known_address(wr_addr_q)) begin
            seen[wr_addr_q[10:2]]++;
            checked++;
        end
    end

    a_store_value: assert property (@(negedge clk) disable iff (!arst_n)
        wr_q |-> known_address(wr_addr_q) && exp_data[wr_addr_q[10:2]] == wr_data_q)
    else begin
        errors++;
        if (!known_address(wr_addr_q)) begin
            $display("Store to unexpected address %h with data %h", wr_addr_q, wr_data_q);
        end else begin
            $display("CHECK FAILED %s expected %h actual %h",
                     exp_name[wr_addr_q[10:2]], exp_data[wr_addr_q[10:2]], wr_data_q);
        end
    end

    a_store_strobe: assert property (@(negedge clk) disable iff (!arst_n)
        wr_q |-> wr_strb_q == 4'b1111)
    else begin
        errors++;
        $display("Store to %h used byte strobes %b instead of a full word",
                 wr_addr_q, wr_strb_q);
    end

    a_reset_quiet: assert property (@(negedge clk) !arst_n |->
        !mem_req.enable && mem_req.write_strobe == 4'b0000 && instruction_address == 32'h0)
    else begin
        errors++;
        $display("Memory request active or fetch address not zero while reset is asserted");
    end

    //////////////////////////////
    // Run control
    //////////////////////////////

    initial begin
        int cycles;
        int drain;
        arst_n  = 1'b0;
        stall   = 1'b0;
        seed    = 32'h4fca;
        errors  = 0;
        checked = 0;
        missing = 0;
        wr_q    = 1'b0;
        cycles  = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;
        while (seen[FINAL_ADDR[10:2]] == 0 && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (seen[FINAL_ADDR[10:2]] == 0) begin
            errors++;
            $display("Timeout, final store never arrived after %0d cycles", cycles);
        end
        // Let any late stray store show up
        drain = 0;
        while (drain < 20) begin
            @(negedge clk);
            drain++;
        end
        for (int i = 0; i < 512; i++) begin
            if (exp_valid[i] && seen[i] == 0) begin
                missing++;
                errors++;
                $display("Store %s to address %h was never seen", exp_name[i], i << 2);
            end else if (exp_valid[i] && seen[i] > 1) begin
                errors++;
                $display("Store %s was issued %0d times", exp_name[i], seen[i]);
            end
        end
        $display("Summary: %0d stores checked, %0d missing, %0d errors",
                 checked, missing, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/rs5_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/regbank.sv
logic/execute.sv
logic/rs5_core.sv
tb/tb_memory.sv
tb/tb_rs5.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RS5 core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_rs5 \
    -o tb_rs5 \
    && ./obj_dir/tb_rs5 > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
